/* verilog/la_consts.svh */
// buffer depth must stay a power of two; thresholds apply to the registered water levels
`ifndef LA_CONSTS_SVH
`define LA_CONSTS_SVH

// ****************************************
// probe and buffer geometry
// ****************************************

`define LA_PROBE_W 8                   // probe bus width

`define LA_DEPTH_W 5                   // buffer address bits
`define LA_DEPTH (1 << `LA_DEPTH_W)    // 32 entries

// pointers and levels carry one extra wrap bit on top of LA_DEPTH_W

`define LA_CNT_W 6                     // post-trigger sample count

// ****************************************
// water-level thresholds
// ****************************************

// write side, flag when level at or above
`define LA_ALMOST_FULL 28

// read side, flag when level at or below
`define LA_ALMOST_EMPTY 2

`endif

/* verilog/la_pkg.sv */
// types only; field widths follow la_consts.svh and la_trig_cfg_t packs to 24 bits
`include "la_consts.svh"

package la_pkg;

    // ****************************************
    // enums
    // ****************************************

    // trigger compare modes, all under cfg.mask
    typedef enum logic [1:0] {
        TRIG_EQUAL  = 2'd0,    // probe matches value
        TRIG_RISE   = 2'd1,    // any bit 0 to 1
        TRIG_FALL   = 2'd2,    // any bit 1 to 0
        TRIG_CHANGE = 2'd3     // any bit toggled
    } trig_mode_e;

    // capture sequence of the trigger unit
    typedef enum logic [1:0] {
        CAP_IDLE  = 2'd0,      // waiting for arm
        CAP_ARMED = 2'd1,      // watching for the condition
        CAP_RUN   = 2'd2,      // storing post-trigger samples
        CAP_DONE  = 2'd3       // terminal until reset
    } cap_state_e;

    // ****************************************
    // structs
    // ****************************************

    typedef struct packed {
        trig_mode_e             mode;
        logic [`LA_PROBE_W-1:0] mask;     // bits taking part in the compare
        logic [`LA_PROBE_W-1:0] value;    // used by TRIG_EQUAL only
        logic [`LA_CNT_W-1:0]   count;    // total samples, 0 acts as 1
    } la_trig_cfg_t;

    typedef struct packed {
        logic                   first;    // set on the triggering sample
        logic [`LA_PROBE_W-1:0] data;
    } la_sample_t;

endpackage

/* verilog/la_trigger.sv */
// cfg must be held static from arm until done; no pre-trigger history and done holds until wrst
`timescale 1ns/1ps
`include "la_consts.svh"

module la_trigger
(
    input  logic                   wclk,
    input  logic                   wrst,
    input  logic                   arm,          // one-cycle pulse
    input  la_pkg::la_trig_cfg_t   cfg,
    input  logic [`LA_PROBE_W-1:0] probe,
    output logic                   wr_strobe,    // store this sample
    output la_pkg::la_sample_t     wr_sample,
    output logic                   armed,
    output logic                   done
);

    localparam logic [`LA_CNT_W-1:0] CNT_ONE = {{(`LA_CNT_W-1){1'b0}}, 1'b1};

    la_pkg::cap_state_e     state;
    logic [`LA_PROBE_W-1:0] prev_probe;     // last cycle's probe for the edge modes
    logic [`LA_CNT_W-1:0]   remain;         // samples still to store after this one
    logic [`LA_CNT_W-1:0]   total_cnt;      // count with zero folded to one
    logic [`LA_PROBE_W-1:0] rise_bits;
    logic [`LA_PROBE_W-1:0] fall_bits;
    logic                   hit;            // condition met on this sample

    // ****************************************
    // trigger compare
    // ****************************************

    assign rise_bits = ~prev_probe & probe & cfg.mask;
    assign fall_bits = prev_probe & ~probe & cfg.mask;

    always_comb
    begin
        case (cfg.mode)
            la_pkg::TRIG_EQUAL:  hit = ((probe & cfg.mask) == (cfg.value & cfg.mask));
            la_pkg::TRIG_RISE:   hit = |rise_bits;
            la_pkg::TRIG_FALL:   hit = |fall_bits;
            la_pkg::TRIG_CHANGE: hit = |((probe ^ prev_probe) & cfg.mask);
            default:             hit = 1'b0;
        endcase
    end

    assign total_cnt = (cfg.count == '0) ? CNT_ONE : cfg.count;

    // ****************************************
    // capture sequence
    // ****************************************

    always_ff @(posedge wclk or posedge wrst)
    begin
        if (wrst)
        begin
            state      <= la_pkg::CAP_IDLE;
            remain     <= '0;
            prev_probe <= '0;
        end
        else
        begin
            prev_probe <= probe;    // tracked in every state
            case (state)
                la_pkg::CAP_IDLE:
                begin
                    if (arm)
                        state <= la_pkg::CAP_ARMED;
                end
                la_pkg::CAP_ARMED:
                begin
                    if (hit)
                    begin
                        remain <= total_cnt - CNT_ONE;
                        // single-sample capture finishes right away
                        if (total_cnt == CNT_ONE)
                            state <= la_pkg::CAP_DONE;
                        else
                            state <= la_pkg::CAP_RUN;
                    end
                end
                la_pkg::CAP_RUN:
                begin
                    remain <= remain - CNT_ONE;
                    if (remain == CNT_ONE)    // last one goes out this cycle
                        state <= la_pkg::CAP_DONE;
                end
                default:
                begin
                    state <= la_pkg::CAP_DONE;    // sticky
                end
            endcase
        end
    end

    // strobe the triggering sample in its own cycle, then every cycle of the run
    assign wr_strobe = ((state == la_pkg::CAP_ARMED) && hit) || (state == la_pkg::CAP_RUN);

    assign wr_sample.first = (state == la_pkg::CAP_ARMED);    // only strobed on a hit
    assign wr_sample.data  = probe;

    assign armed = (state == la_pkg::CAP_ARMED);
    assign done  = (state == la_pkg::CAP_DONE);

endmodule

/* verilog/la_fifo_ctrl.sv */
// equal write and read widths only; far-side levels lag by the two-flop synchronizer delay
`timescale 1ns/1ps
`include "la_consts.svh"

module la_fifo_ctrl
(
    // write side
    input  logic                  wclk,
    input  logic                  wrst,
    input  logic                  wr_strobe,
    output logic                  wr_accept,
    output logic [`LA_DEPTH_W-1:0] waddr,
    output logic                  wfull,
    output logic                  almost_full,
    output logic [`LA_DEPTH_W:0]  wr_level,
    output logic                  overflow,      // sticky until wrst
    // read side
    input  logic                  rclk,
    input  logic                  rrst,
    input  logic                  r_en,
    output logic                  rd_accept,
    output logic [`LA_DEPTH_W-1:0] raddr,
    output logic                  rempty,
    output logic                  almost_empty,
    output logic [`LA_DEPTH_W:0]  rd_level
);

    localparam int AW = `LA_DEPTH_W;

    localparam logic [AW:0] AFULL_LVL  = (AW+1)'(`LA_ALMOST_FULL);
    localparam logic [AW:0] AEMPTY_LVL = (AW+1)'(`LA_ALMOST_EMPTY);

    // write domain
    logic [AW:0] wbin;       // binary pointer, addresses the buffer
    logic [AW:0] wbnext;
    logic [AW:0] wgnext;
    logic [AW:0] wptr;       // gray pointer, crosses to rclk
    logic [AW:0] wq1_rptr;   // first sync stage
    logic [AW:0] wq2_rptr;   // second sync stage
    logic [AW:0] wq2_bin;

    // read domain
    logic [AW:0] rbin;
    logic [AW:0] rbnext;
    logic [AW:0] rgnext;
    logic [AW:0] rptr;       // gray, crosses to wclk
    logic [AW:0] rq1_wptr;
    logic [AW:0] rq2_wptr;
    logic [AW:0] rq2_bin;

    function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
        logic [AW:0] b;
        for (int i = 0; i <= AW; i++)
        begin
            b[i] = ^(g >> i);    // xor of all bits at and above i
        end
        return b;
    endfunction

    // ****************************************
    // write pointer
    // ****************************************

    assign wr_accept = wr_strobe & ~wfull;    // a strobe into full is lost
    assign wbnext    = wbin + {{AW{1'b0}}, wr_accept};
    assign wgnext    = (wbnext >> 1) ^ wbnext;

    always_ff @(posedge wclk or posedge wrst)
    begin
        if (wrst)
        begin
            wbin <= '0;
            wptr <= '0;
        end
        else
        begin
            wbin <= wbnext;
            wptr <= wgnext;
        end
    end

    assign waddr = wbin[AW-1:0];

    // read pointer into wclk
    always_ff @(posedge wclk or posedge wrst)
    begin
        if (wrst)
        begin
            wq1_rptr <= '0;
            wq2_rptr <= '0;
        end
        else
        begin
            wq1_rptr <= rptr;
            wq2_rptr <= wq1_rptr;
        end
    end

    assign wq2_bin = gray2bin(wq2_rptr);

    // full when wrap bits differ and the rest matches
    always_ff @(posedge wclk or posedge wrst)
    begin
        if (wrst)
        begin
            wfull    <= 1'b0;
            wr_level <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            wfull    <= (wbnext[AW] != wq2_bin[AW]) && (wbnext[AW-1:0] == wq2_bin[AW-1:0]);
            wr_level <= wbnext - wq2_bin;    // modulo 2**(AW+1)
            if (wr_strobe && wfull)
                overflow <= 1'b1;
        end
    end

    assign almost_full = (wr_level >= AFULL_LVL);

    // ****************************************
    // read pointer
    // ****************************************

    assign rd_accept = r_en & ~rempty;    // read on empty ignored
    assign rbnext    = rbin + {{AW{1'b0}}, rd_accept};
    assign rgnext    = (rbnext >> 1) ^ rbnext;

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            rbin <= '0;
            rptr <= '0;
        end
        else
        begin
            rbin <= rbnext;
            rptr <= rgnext;
        end
    end

    assign raddr = rbin[AW-1:0];

    // write pointer into rclk
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            rq1_wptr <= '0;
            rq2_wptr <= '0;
        end
        else
        begin
            rq1_wptr <= wptr;
            rq2_wptr <= rq1_wptr;
        end
    end

    assign rq2_bin = gray2bin(rq2_wptr);

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            rempty   <= 1'b1;
            rd_level <= '0;
        end
        else
        begin
            rempty   <= (rbnext == rq2_bin);
            rd_level <= rq2_bin - rbnext;
        end
    end

    assign almost_empty = (rd_level <= AEMPTY_LVL);

endmodule

/* verilog/la_sample_ram.sv */
// write and read enables must already be qualified by the controller; contents are undefined after reset
`timescale 1ns/1ps
`include "la_consts.svh"

module la_sample_ram
(
    // write side
    input  logic                   wclk,
    input  logic                   wr_accept,
    input  logic [`LA_DEPTH_W-1:0] waddr,
    input  la_pkg::la_sample_t     wr_sample,
    // read side
    input  logic                   rclk,
    input  logic                   rrst,
    input  logic                   rd_accept,
    input  logic [`LA_DEPTH_W-1:0] raddr,
    output la_pkg::la_sample_t     rd_sample,
    output logic                   rd_valid     // one rclk after rd_accept
);

    la_pkg::la_sample_t mem [0:`LA_DEPTH-1];

    always_ff @(posedge wclk)
    begin
        if (wr_accept)
            mem[waddr] <= wr_sample;
    end

    // registered read port, holds the last sample between reads
    always_ff @(posedge rclk)
    begin
        if (rd_accept)
            rd_sample <= mem[raddr];
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd_accept;
    end

endmodule

/* verilog/la_capture_top.sv */
// cfg and arm belong to wclk, r_en to rclk; the two resets are independent but both must be applied
`timescale 1ns/1ps
`include "la_consts.svh"

module la_capture_top
(
    input  logic                   wclk,
    input  logic                   wrst,
    input  logic                   rclk,
    input  logic                   rrst,
    input  logic                   arm,
    input  la_pkg::la_trig_cfg_t   cfg,
    input  logic [`LA_PROBE_W-1:0] probe,
    input  logic                   r_en,
    output logic                   armed,
    output logic                   done,
    output logic                   overflow,
    output logic                   wfull,
    output logic                   almost_full,
    output logic [`LA_DEPTH_W:0]   wr_level,
    output logic                   rempty,
    output logic                   almost_empty,
    output logic [`LA_DEPTH_W:0]   rd_level,
    output la_pkg::la_sample_t     rd_sample,
    output logic                   rd_valid
);

    logic                   wr_strobe;
    la_pkg::la_sample_t     wr_sample;
    logic                   wr_accept;    // strobe that found room
    logic [`LA_DEPTH_W-1:0] waddr;
    logic                   rd_accept;    // r_en that found data
    logic [`LA_DEPTH_W-1:0] raddr;

    // ****************************************
    // sample domain front end
    // ****************************************

    la_trigger i_la_trigger
    (
        .wclk      (wclk),
        .wrst      (wrst),
        .arm       (arm),
        .cfg       (cfg),
        .probe     (probe),
        .wr_strobe (wr_strobe),
        .wr_sample (wr_sample),
        .armed     (armed),
        .done      (done)
    );

    // pointers, flags and levels for both domains
    la_fifo_ctrl i_la_fifo_ctrl
    (
        .wclk         (wclk),
        .wrst         (wrst),
        .wr_strobe    (wr_strobe),
        .wr_accept    (wr_accept),
        .waddr        (waddr),
        .wfull        (wfull),
        .almost_full  (almost_full),
        .wr_level     (wr_level),
        .overflow     (overflow),
        .rclk         (rclk),
        .rrst         (rrst),
        .r_en         (r_en),
        .rd_accept    (rd_accept),
        .raddr        (raddr),
        .rempty       (rempty),
        .almost_empty (almost_empty),
        .rd_level     (rd_level)
    );

    la_sample_ram i_la_sample_ram
    (
        .wclk      (wclk),
        .wr_accept (wr_accept),
        .waddr     (waddr),
        .wr_sample (wr_sample),
        .rclk      (rclk),
        .rrst      (rrst),
        .rd_accept (rd_accept),
        .raddr     (raddr),
        .rd_sample (rd_sample),
        .rd_valid  (rd_valid)
    );

endmodule

/* testbench/tb_la_capture.sv */
// reads testbench/la_golden.txt from the project root; run from there, wclk 10 ns and rclk 8 ns
`timescale 1ns/1ps
`include "la_consts.svh"

module tb_la_capture;

    localparam int WCLK_NS = 10;
    localparam int RCLK_NS = 8;
    localparam int MAX_REC = 8;      // golden records
    localparam int MAX_VAL = 256;    // probe and sample table depth

    logic                   wclk = 1'b0;
    logic                   rclk = 1'b0;
    logic                   wrst;
    logic                   rrst;
    logic                   arm;
    logic                   r_en;
    la_pkg::la_trig_cfg_t   cfg;
    logic [`LA_PROBE_W-1:0] probe;
    logic                   armed;
    logic                   done;
    logic                   overflow;
    logic                   wfull;
    logic                   almost_full;
    logic                   rempty;
    logic                   almost_empty;
    logic                   rd_valid;
    logic [`LA_DEPTH_W:0]   wr_level;
    logic [`LA_DEPTH_W:0]   rd_level;
    la_pkg::la_sample_t     rd_sample;

    // golden records, one slot per test
    string rec_name [MAX_REC];
    int    rec_kind [MAX_REC];    // 0 plain, 1 water levels, 2 irregular reads
    int    rec_mode [MAX_REC];
    int    rec_mask [MAX_REC];
    int    rec_value[MAX_REC];
    int    rec_count[MAX_REC];
    int    rec_np   [MAX_REC];
    int    rec_ne   [MAX_REC];
    int    rec_ovf  [MAX_REC];
    int    rec_full [MAX_REC];
    int    rec_afull[MAX_REC];
    int    rec_wlvl [MAX_REC];
    int    rec_poff [MAX_REC];    // offset into probe_tab
    int    rec_eoff [MAX_REC];    // offset into exp tables
    int    probe_tab[MAX_VAL];
    int    exp_first[MAX_VAL];
    int    exp_data [MAX_VAL];

    int   n_rec;
    int   total_len;              // sum of probe lengths, sizes the watchdog
    logic loaded = 1'b0;
    int   err_cnt;
    int   test_err;
    int   fail_tests;
    int   tests_run;
    int   exp_idx;                // next expected sample
    int   exp_end;

    always #(WCLK_NS/2) wclk = ~wclk;
    always #(RCLK_NS/2) rclk = ~rclk;

    la_capture_top i_la_capture_top (.*);

    // ****************************************
    // helpers
    // ****************************************

    task automatic check_val(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("Fail %s expected %h got %h", name, exp, act);
            err_cnt++;
            test_err++;
        end
    endtask

    task automatic complain(input string what);
        $display("%s", what);    // non-value failure, plain words
        err_cnt++;
        test_err++;
    endtask

    task automatic load_golden();
        int fd;
        int code;
        int np;
        int ne;
        logic [8*256-1:0] line;
        n_rec = 0;
        total_len = 0;
        fd = $fopen("testbench/la_golden.txt", "r");
        if (fd == 0)
            $display("cannot open testbench/la_golden.txt");
        else
        begin
            code = $fgets(line, fd);    // two column note lines
            code = $fgets(line, fd);
            np = 0;
            ne = 0;
            while (n_rec < MAX_REC && $fscanf(fd, "%s", rec_name[n_rec]) == 1)
            begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                               rec_kind[n_rec], rec_mode[n_rec], rec_mask[n_rec],
                               rec_value[n_rec], rec_count[n_rec], rec_np[n_rec],
                               rec_ne[n_rec], rec_ovf[n_rec], rec_full[n_rec],
                               rec_afull[n_rec], rec_wlvl[n_rec]);
                rec_poff[n_rec] = np;
                rec_eoff[n_rec] = ne;
                for (int i = 0; i < rec_np[n_rec]; i++)
                begin
                    code = $fscanf(fd, "%h", probe_tab[np]);
                    np++;
                end
                for (int i = 0; i < rec_ne[n_rec]; i++)
                begin
                    code = $fscanf(fd, "%h %h", exp_first[ne], exp_data[ne]);
                    ne++;
                end
                total_len += rec_np[n_rec];
                n_rec++;
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        wrst = 1'b1;
        rrst = 1'b1;
        arm  = 1'b0;
        r_en = 1'b0;
        probe = '0;
        repeat (16) @(posedge wclk);    // covers 16 rclk as well
        #1;
        wrst = 1'b0;
        @(posedge rclk);
        #1;
        rrst = 1'b0;
        repeat (2) @(posedge wclk);
        #1;
    endtask

    task automatic load_cfg(input int r);
        cfg.mode  = la_pkg::trig_mode_e'(rec_mode[r][1:0]);
        cfg.mask  = rec_mask[r][`LA_PROBE_W-1:0];
        cfg.value = rec_value[r][`LA_PROBE_W-1:0];
        cfg.count = rec_count[r][`LA_CNT_W-1:0];
        exp_idx   = rec_eoff[r];
        exp_end   = rec_eoff[r] + rec_ne[r];
    endtask

    // arm cycle carries probe 0, trigger candidates start at probe 1
    task automatic run_capture(input int r);
        int cyc;
        @(posedge wclk);
        #1;
        arm   = 1'b1;
        probe = probe_tab[rec_poff[r]][`LA_PROBE_W-1:0];
        for (int i = 1; i < rec_np[r]; i++)
        begin
            @(posedge wclk);
            #1;
            if (i == 1)
                check_val("armed", 1, int'(armed));    // arm seen on this edge
            arm   = 1'b0;
            probe = probe_tab[rec_poff[r] + i][`LA_PROBE_W-1:0];
        end
        cyc = 0;
        do
        begin
            @(posedge wclk);
            #1;
            arm = 1'b0;
            cyc++;
        end
        while (!done && cyc < 100);
        if (!done)
            complain("capture never reached done");
        check_val("armed", 0, int'(armed));
    endtask

    task automatic check_sample();
        if (exp_idx >= exp_end)
            complain("sample read beyond the expected list");
        else
        begin
            check_val("rd_sample.first", exp_first[exp_idx], int'(rd_sample.first));
            check_val("rd_sample.data", exp_data[exp_idx], int'(rd_sample.data));
            exp_idx++;
        end
    endtask

    // pops n samples; gaps come from $urandom when rand_gaps is set
    task automatic read_samples(input int n, input bit rand_gaps, input int max_cyc);
        int   issued;
        int   got;
        int   cyc;
        logic was_empty;
        logic want;
        issued    = 0;
        got       = 0;
        cyc       = 0;
        was_empty = 1'b1;
        while (got < n && cyc < max_cyc)
        begin
            @(posedge rclk);
            #1;
            cyc++;
            if (r_en && !was_empty)    // accepted on this edge
                issued++;
            if (rd_valid)
            begin
                check_sample();
                got++;
            end
            want = rand_gaps ? (($urandom % 3) == 0) : 1'b1;
            r_en = want && (issued < n);
            was_empty = rempty;
        end
        r_en = 1'b0;
        if (got < n)
            complain($sformatf("read stalled, %0d of %0d samples arrived", got, n));
    endtask

    task automatic check_flags(input int r);
        repeat (12) @(posedge wclk);    // past the synchronizer delay
        #1;
        check_val("overflow", rec_ovf[r], int'(overflow));
        check_val("wfull", rec_full[r], int'(wfull));
        check_val("almost_full", rec_afull[r], int'(almost_full));
        check_val("wr_level", rec_wlvl[r], int'(wr_level));
    endtask

    task automatic check_drained();
        repeat (6) @(posedge rclk);
        #1;
        check_val("rempty", 1, int'(rempty));
        check_val("rd_valid", 0, int'(rd_valid));
        if (exp_idx != exp_end)
            complain("fewer samples read than expected");
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_err == 0)
            $display("test %0d %s ok", tests_run, name);
        else
        begin
            fail_tests++;
            $display("test %0d %s failed with %0d errors", tests_run, name, test_err);
        end
    endtask

    // ****************************************
    // main sequence
    // ****************************************

    initial
    begin
        wrst = 1'b1;
        rrst = 1'b1;
        arm  = 1'b0;
        r_en = 1'b0;
        probe = '0;
        cfg  = '0;
        err_cnt = 0;
        fail_tests = 0;
        tests_run = 0;
        void'($urandom(291));
        load_golden();
        loaded = 1'b1;

        test_err = 0;
        apply_reset();
        check_val("rempty", 1, int'(rempty));
        check_val("almost_empty", 1, int'(almost_empty));
        check_val("done", 0, int'(done));
        check_val("armed", 0, int'(armed));
        check_val("overflow", 0, int'(overflow));
        check_val("wfull", 0, int'(wfull));
        check_val("almost_full", 0, int'(almost_full));
        check_val("rd_valid", 0, int'(rd_valid));
        check_val("wr_level", 0, int'(wr_level));
        check_val("rd_level", 0, int'(rd_level));
        finish_test("reset");

        for (int r = 0; r < n_rec; r++)
        begin
            test_err = 0;
            load_cfg(r);
            apply_reset();
            if (rec_kind[r] == 2)
            begin
                fork
                    run_capture(r);
                    read_samples(rec_ne[r], 1'b1, 2000);
                join
                check_drained();
            end
            else
            begin
                run_capture(r);
                check_flags(r);
                if (rec_kind[r] == 1)
                begin
                    @(posedge rclk);
                    #1;
                    check_val("rd_level", rec_ne[r], int'(rd_level));
                    check_val("almost_empty", 0, int'(almost_empty));
                    read_samples(8, 1'b0, 200);
                    repeat (8) @(posedge rclk);
                    #1;
                    check_val("rd_level", rec_ne[r] - 8, int'(rd_level));
                    check_val("almost_empty", 1, int'(almost_empty));
                    read_samples(rec_ne[r] - 8, 1'b0, 200);
                end
                else
                    read_samples(rec_ne[r], 1'b0, 400);
                check_drained();
            end
            finish_test(rec_name[r]);
        end

        $display("tests %0d, failed %0d, check errors %0d", tests_run, fail_tests, err_cnt);
        if (err_cnt == 0 && fail_tests == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // watchdog, 20 wclk periods per probe value
    initial
    begin
        wait (loaded);
        if (n_rec == 0)
        begin
            $display("no test records could be read from the golden file");
            $display("TB FAILED");
            $finish;
        end
        else
        begin
            #(total_len * 20 * WCLK_NS);
            $display("watchdog expired before the tests finished");
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

/* testbench/la_golden.txt */
# name kind mode mask value count nprobe nexp overflow wfull almost_full wr_level (hex)
# then nprobe probe values, then nexp pairs of first and data (hex)
equal 0 0 f0 a0 0a 0f 0a 0 0 0 0a
00 11 22 a5 37 48 59 6a 7b 8c 9d ae bf c0 d1
1 a5 0 37 0 48 0 59 0 6a 0 7b 0 8c 0 9d 0 ae 0 bf
rise 0 1 01 00 04 0a 04 0 0 0 04
01 01 00 00 01 02 03 04 05 06
1 01 0 02 0 03 0 04
fall 0 2 80 00 03 08 03 0 0 0 03
00 80 80 81 7f 10 20 30
1 7f 0 10 0 20
change 0 3 0c 00 05 0a 05 0 0 0 05
03 03 f3 f1 07 55 66 77 88 99
1 07 0 55 0 66 0 77 0 88
overflow 0 0 00 00 28 29 20 1 1 1 20
ff 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13
14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27
1 00 0 01 0 02 0 03 0 04 0 05 0 06 0 07
0 08 0 09 0 0a 0 0b 0 0c 0 0d 0 0e 0 0f
0 10 0 11 0 12 0 13 0 14 0 15 0 16 0 17
0 18 0 19 0 1a 0 1b 0 1c 0 1d 0 1e 0 1f
levels 1 0 ff 5a 0a 0c 0a 0 0 0 0a
00 5a 11 22 33 44 55 66 77 88 99 aa
1 5a 0 11 0 22 0 33 0 44 0 55 0 66 0 77 0 88 0 99
irregular 2 1 10 00 14 16 14 0 0 0 00
10 00 10 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33
1 10 0 21 0 22 0 23 0 24 0 25 0 26 0 27 0 28 0 29
0 2a 0 2b 0 2c 0 2d 0 2e 0 2f 0 30 0 31 0 32 0 33

/* list.f */
+incdir+verilog
verilog/la_pkg.sv
verilog/la_trigger.sv
verilog/la_fifo_ctrl.sv
verilog/la_sample_ram.sv
verilog/la_capture_top.sv
testbench/tb_la_capture.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing
TOP   = tb_la_capture
FLIST = list.f

OBJ  = obj_dir
BIN  = $(OBJ)/V$(TOP)
SRCS = $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv) $(FLIST)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ)
